//--- hdl/axis_skid_buf.sv
// two-register output stage for the payload stream
// buf_in_valid marks a byte already accepted upstream, it cannot be refused
// the source must take buf_ready_early through a register as its ready
`timescale 1ns/1ns

module axis_skid_buf (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ip_rx_pkg::pay_beat_t buf_in,
    input  logic                 buf_in_valid,
    output ip_rx_pkg::pay_beat_t m_pay,
    output logic                 m_pay_valid,
    input  logic                 m_pay_ready,
    output logic                 buf_ready_early
);

    ip_rx_pkg::pay_beat_t tmp_beat;
    logic                 tmp_valid;
    logic                 out_valid_d, tmp_valid_d;
    logic                 in_to_out, in_to_tmp, tmp_to_out;

    // room next cycle if the sink drains now or nothing is held
    assign buf_ready_early = m_pay_ready || (!tmp_valid && !m_pay_valid);

    always_comb begin
        out_valid_d = m_pay_valid;
        tmp_valid_d = tmp_valid;
        in_to_out = 1'b0;
        in_to_tmp = 1'b0;
        tmp_to_out = 1'b0;

        if (buf_in_valid) begin
            if (m_pay_ready || !m_pay_valid) begin
                out_valid_d = 1'b1;
                in_to_out = 1'b1;
            end else begin
                // output stalled, park the byte
                tmp_valid_d = 1'b1;
                in_to_tmp = 1'b1;
            end
        end else if (m_pay_ready) begin
            out_valid_d = tmp_valid;
            tmp_valid_d = 1'b0;
            tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_pay_valid <= 1'b0;
            tmp_valid <= 1'b0;
        end else begin
            m_pay_valid <= out_valid_d;
            tmp_valid <= tmp_valid_d;
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            m_pay <= buf_in;
        end else if (tmp_to_out) begin
            m_pay <= tmp_beat;
        end
        if (in_to_tmp) begin
            tmp_beat <= buf_in;
        end
    end

endmodule

//--- hdl/ip_eth_rx.sv
// IPv4 receiver, Ethernet header and byte payload in, IP header and payload out
// only 20-byte headers are accepted, frames with options are rejected
// Ethernet padding past the IP length is not removed
`timescale 1ns/1ns

module ip_eth_rx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ip_rx_pkg::eth_hdr_t  s_eth_hdr,
    input  logic                 s_eth_hdr_valid,
    output logic                 s_eth_hdr_ready,
    input  ip_rx_pkg::pay_beat_t s_pay,
    input  logic                 s_pay_valid,
    output logic                 s_pay_ready,
    output ip_rx_pkg::eth_hdr_t  m_eth_hdr,
    output ip_rx_pkg::ip_hdr_t   m_ip_hdr,
    output logic                 m_hdr_valid,
    input  logic                 m_hdr_ready,
    output ip_rx_pkg::pay_beat_t m_pay,
    output logic                 m_pay_valid,
    input  logic                 m_pay_ready,
    output logic                 busy,
    output logic                 err_hdr_early,
    output logic                 err_pay_early,
    output logic                 err_bad_header,
    output logic                 err_bad_sum
);

    logic                   frame_start;
    logic                   hdr_beat;
    logic                   hdr_done;
    ip_rx_pkg::hdr_status_e hdr_status;
    ip_rx_pkg::pay_beat_t   buf_in;
    logic                   buf_in_valid;
    logic                   buf_ready_early;

    ip_hdr_parser u_parser (
        .clk        (clk),
        .rst_n      (rst_n),
        .frame_start(frame_start),
        .hdr_beat   (hdr_beat),
        .hdr_byte   (s_pay.data),
        .ip_hdr     (m_ip_hdr),
        .hdr_done   (hdr_done),
        .hdr_status (hdr_status)
    );

    ip_rx_fsm u_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .s_eth_hdr      (s_eth_hdr),
        .s_eth_hdr_valid(s_eth_hdr_valid),
        .s_eth_hdr_ready(s_eth_hdr_ready),
        .s_pay          (s_pay),
        .s_pay_valid    (s_pay_valid),
        .s_pay_ready    (s_pay_ready),
        .m_eth_hdr      (m_eth_hdr),
        .m_hdr_valid    (m_hdr_valid),
        .m_hdr_ready    (m_hdr_ready),
        .frame_start    (frame_start),
        .hdr_beat       (hdr_beat),
        .hdr_done       (hdr_done),
        .hdr_status     (hdr_status),
        .ip_length      (m_ip_hdr.length),
        .buf_in         (buf_in),
        .buf_in_valid   (buf_in_valid),
        .buf_ready_early(buf_ready_early),
        .busy           (busy),
        .err_hdr_early  (err_hdr_early),
        .err_pay_early  (err_pay_early),
        .err_bad_header (err_bad_header),
        .err_bad_sum    (err_bad_sum)
    );

    axis_skid_buf u_pay_buf (
        .clk            (clk),
        .rst_n          (rst_n),
        .buf_in         (buf_in),
        .buf_in_valid   (buf_in_valid),
        .m_pay          (m_pay),
        .m_pay_valid    (m_pay_valid),
        .m_pay_ready    (m_pay_ready),
        .buf_ready_early(buf_ready_early)
    );

endmodule

//--- hdl/ip_hdr_parser.sv
// IPv4 header field capture and checksum check
// expects exactly one frame_start before the first header byte
// verdict and hdr_done are valid only in the cycle of the 20th byte
// version and IHL are checked against the fixed values, no options
`timescale 1ns/1ns

module ip_hdr_parser (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   frame_start,
    input  logic                   hdr_beat,
    input  ip_rx_pkg::byte_t       hdr_byte,
    output ip_rx_pkg::ip_hdr_t     ip_hdr,
    output logic                   hdr_done,
    output ip_rx_pkg::hdr_status_e hdr_status
);

    localparam logic [4:0] LAST_PTR = 5'(ip_rx_pkg::IP_HDR_BYTES - 1);

    logic [4:0]         hdr_ptr;
    logic [15:0]        sum_q;
    logic [15:0]        sum_next;
    logic [15:0]        sum_word;
    ip_rx_pkg::ip_hdr_t hdr_q;

    // 16-bit add with end-around carry
    function automatic logic [15:0] add_ones(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] t;
        t = {1'b0, a} + {1'b0, b};
        return t[15:0] + {15'd0, t[16]};
    endfunction

    // even offsets are the high byte of a 16-bit word
    assign sum_word = hdr_ptr[0] ? {8'h00, hdr_byte} : {hdr_byte, 8'h00};
    assign sum_next = add_ones(sum_q, sum_word);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdr_ptr <= '0;
            sum_q <= '0;
        end else if (frame_start) begin
            hdr_ptr <= '0;
            sum_q <= '0;
        end else if (hdr_beat) begin
            hdr_ptr <= hdr_ptr + 5'd1;
            sum_q <= sum_next;
        end
    end

    // field registers, steered by byte offset
    always_ff @(posedge clk) begin
        if (hdr_beat) begin
            case (hdr_ptr)
                ip_rx_pkg::OFF_VER_IHL:    {hdr_q.version, hdr_q.ihl} <= hdr_byte;
                ip_rx_pkg::OFF_DSCP_ECN:   {hdr_q.dscp, hdr_q.ecn} <= hdr_byte;
                ip_rx_pkg::OFF_LENGTH:     hdr_q.length[15:8] <= hdr_byte;
                ip_rx_pkg::OFF_LENGTH + 1: hdr_q.length[7:0] <= hdr_byte;
                ip_rx_pkg::OFF_IDENT:      hdr_q.identification[15:8] <= hdr_byte;
                ip_rx_pkg::OFF_IDENT + 1:  hdr_q.identification[7:0] <= hdr_byte;
                ip_rx_pkg::OFF_FLAGS_FRAG: begin
                    {hdr_q.flags, hdr_q.fragment_offset[12:8]} <= hdr_byte;
                end
                ip_rx_pkg::OFF_FLAGS_FRAG + 1: hdr_q.fragment_offset[7:0] <= hdr_byte;
                ip_rx_pkg::OFF_TTL:        hdr_q.ttl <= hdr_byte;
                ip_rx_pkg::OFF_PROTOCOL:   hdr_q.protocol <= hdr_byte;
                ip_rx_pkg::OFF_CHECKSUM:   hdr_q.header_checksum[15:8] <= hdr_byte;
                ip_rx_pkg::OFF_CHECKSUM + 1: hdr_q.header_checksum[7:0] <= hdr_byte;
                ip_rx_pkg::OFF_SRC_IP:     hdr_q.source_ip[31:24] <= hdr_byte;
                ip_rx_pkg::OFF_SRC_IP + 1: hdr_q.source_ip[23:16] <= hdr_byte;
                ip_rx_pkg::OFF_SRC_IP + 2: hdr_q.source_ip[15:8] <= hdr_byte;
                ip_rx_pkg::OFF_SRC_IP + 3: hdr_q.source_ip[7:0] <= hdr_byte;
                ip_rx_pkg::OFF_DEST_IP:    hdr_q.dest_ip[31:24] <= hdr_byte;
                ip_rx_pkg::OFF_DEST_IP + 1: hdr_q.dest_ip[23:16] <= hdr_byte;
                ip_rx_pkg::OFF_DEST_IP + 2: hdr_q.dest_ip[15:8] <= hdr_byte;
                ip_rx_pkg::OFF_DEST_IP + 3: hdr_q.dest_ip[7:0] <= hdr_byte;
                default: ;
            endcase
        end
    end

    assign ip_hdr = hdr_q;

    // last byte is odd, so it enters the sum as the low byte
    assign hdr_done = hdr_beat && (hdr_ptr == LAST_PTR);

    // format errors take priority over the checksum
    always_comb begin
        if (hdr_q.version != ip_rx_pkg::IP_VERSION_4 || hdr_q.ihl != ip_rx_pkg::IP_IHL_MIN) begin
            hdr_status = ip_rx_pkg::HDR_BAD_FORMAT;
        end else if (sum_next != 16'hffff) begin
            hdr_status = ip_rx_pkg::HDR_BAD_SUM;
        end else begin
            hdr_status = ip_rx_pkg::HDR_OK;
        end
    end

endmodule

//--- hdl/ip_rx_fsm.sv
// frame control for the IPv4 receiver
// payload beyond the IP length is passed on unchanged up to its last byte
// a last flag inside the header wins over any header verdict
// error outputs are single-cycle pulses, registered
`timescale 1ns/1ns

module ip_rx_fsm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  ip_rx_pkg::eth_hdr_t    s_eth_hdr,
    input  logic                   s_eth_hdr_valid,
    output logic                   s_eth_hdr_ready,
    input  ip_rx_pkg::pay_beat_t   s_pay,
    input  logic                   s_pay_valid,
    output logic                   s_pay_ready,
    output ip_rx_pkg::eth_hdr_t    m_eth_hdr,
    output logic                   m_hdr_valid,
    input  logic                   m_hdr_ready,
    output logic                   frame_start,
    output logic                   hdr_beat,
    input  logic                   hdr_done,
    input  ip_rx_pkg::hdr_status_e hdr_status,
    input  logic [15:0]            ip_length,
    output ip_rx_pkg::pay_beat_t   buf_in,
    output logic                   buf_in_valid,
    input  logic                   buf_ready_early,
    output logic                   busy,
    output logic                   err_hdr_early,
    output logic                   err_pay_early,
    output logic                   err_bad_header,
    output logic                   err_bad_sum
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ_HDR,
        ST_READ_PAY,
        ST_WAIT_LAST
    } state_t;

    state_t      state_q, state_d;
    logic [15:0] pay_count, pay_count_d;
    logic        pay_xfer;
    logic        eth_rdy_d, pay_rdy_d, hdr_valid_d;
    logic        hdr_early_d, pay_early_d, bad_header_d, bad_sum_d;

    assign frame_start = s_eth_hdr_valid && s_eth_hdr_ready;
    assign pay_xfer = s_pay_valid && s_pay_ready;
    assign hdr_beat = pay_xfer && (state_q == ST_READ_HDR);

    always_comb begin
        state_d = state_q;
        pay_count_d = pay_count;
        eth_rdy_d = 1'b0;
        pay_rdy_d = 1'b0;
        hdr_valid_d = m_hdr_valid && !m_hdr_ready;
        hdr_early_d = 1'b0;
        pay_early_d = 1'b0;
        bad_header_d = 1'b0;
        bad_sum_d = 1'b0;
        buf_in = s_pay;
        buf_in_valid = 1'b0;

        case (state_q)
            ST_IDLE: begin
                // hold off the next frame until the header is taken
                eth_rdy_d = !hdr_valid_d;
                if (frame_start) begin
                    eth_rdy_d = 1'b0;
                    pay_rdy_d = 1'b1;
                    state_d = ST_READ_HDR;
                end
            end
            ST_READ_HDR: begin
                pay_rdy_d = 1'b1;
                if (pay_xfer && s_pay.last) begin
                    hdr_early_d = 1'b1;
                    eth_rdy_d = !hdr_valid_d;
                    pay_rdy_d = 1'b0;
                    state_d = ST_IDLE;
                end else if (hdr_done) begin
                    pay_count_d = ip_length - 16'(ip_rx_pkg::IP_HDR_BYTES);
                    case (hdr_status)
                        ip_rx_pkg::HDR_OK: begin
                            hdr_valid_d = 1'b1;
                            pay_rdy_d = buf_ready_early;
                            state_d = ST_READ_PAY;
                        end
                        ip_rx_pkg::HDR_BAD_FORMAT: begin
                            bad_header_d = 1'b1;
                            state_d = ST_WAIT_LAST;
                        end
                        default: begin
                            bad_sum_d = 1'b1;
                            state_d = ST_WAIT_LAST;
                        end
                    endcase
                end
            end
            ST_READ_PAY: begin
                pay_rdy_d = buf_ready_early;
                if (pay_xfer) begin
                    buf_in_valid = 1'b1;
                    // stop at zero on frames longer than the IP length
                    if (pay_count != 16'd0) begin
                        pay_count_d = pay_count - 16'd1;
                    end
                    if (s_pay.last) begin
                        // short frame, mark the final byte bad
                        if (pay_count > 16'd1) begin
                            buf_in.user = 1'b1;
                            pay_early_d = 1'b1;
                        end
                        eth_rdy_d = !hdr_valid_d;
                        pay_rdy_d = 1'b0;
                        state_d = ST_IDLE;
                    end
                end
            end
            default: begin
                // drop the rest of a rejected frame
                pay_rdy_d = 1'b1;
                if (pay_xfer && s_pay.last) begin
                    eth_rdy_d = !hdr_valid_d;
                    pay_rdy_d = 1'b0;
                    state_d = ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            pay_count <= '0;
            s_eth_hdr_ready <= 1'b0;
            s_pay_ready <= 1'b0;
            m_hdr_valid <= 1'b0;
            busy <= 1'b0;
            err_hdr_early <= 1'b0;
            err_pay_early <= 1'b0;
            err_bad_header <= 1'b0;
            err_bad_sum <= 1'b0;
        end else begin
            state_q <= state_d;
            pay_count <= pay_count_d;
            s_eth_hdr_ready <= eth_rdy_d;
            s_pay_ready <= pay_rdy_d;
            m_hdr_valid <= hdr_valid_d;
            busy <= (state_d != ST_IDLE);
            err_hdr_early <= hdr_early_d;
            err_pay_early <= pay_early_d;
            err_bad_header <= bad_header_d;
            err_bad_sum <= bad_sum_d;
        end
    end

    always_ff @(posedge clk) begin
        if (frame_start) begin
            m_eth_hdr <= s_eth_hdr;
        end
    end

endmodule

//--- hdl/ip_rx_pkg.sv
// shared types and constants for the IPv4 byte-stream receiver
// only the fixed 20-byte header is handled, options are not parsed
// struct members follow wire order, so the first byte on the wire
// lands in the most significant bits
package ip_rx_pkg;

    typedef logic [7:0] byte_t;

    // fixed header geometry
    localparam int IP_HDR_BYTES = 20;
    localparam logic [3:0] IP_VERSION_4 = 4'd4;
    localparam logic [3:0] IP_IHL_MIN = 4'd5;

    // byte offsets of the multi-byte fields, first byte of each
    localparam int OFF_VER_IHL = 0;
    localparam int OFF_DSCP_ECN = 1;
    localparam int OFF_LENGTH = 2;
    localparam int OFF_IDENT = 4;
    localparam int OFF_FLAGS_FRAG = 6;
    localparam int OFF_TTL = 8;
    localparam int OFF_PROTOCOL = 9;
    localparam int OFF_CHECKSUM = 10;
    localparam int OFF_SRC_IP = 12;
    localparam int OFF_DEST_IP = 16;

    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ip_hdr_t;

    // one payload byte with its frame flags
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } pay_beat_t;

    // verdict on a complete header
    typedef enum logic [1:0] {
        HDR_OK         = 2'd0,
        HDR_BAD_FORMAT = 2'd1,
        HDR_BAD_SUM    = 2'd2
    } hdr_status_e;

endpackage

//--- ip_eth_rx.f
hdl/ip_rx_pkg.sv
hdl/ip_hdr_parser.sv
hdl/ip_rx_fsm.sv
hdl/axis_skid_buf.sv
hdl/ip_eth_rx.sv
tb/tb_clkgen.sv
tb/ip_eth_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the IPv4 receiver testbench with Verilator and runs it
# the verdict is taken from sim.log in the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module ip_eth_rx_tb \
    -f ip_eth_rx.f \
    && ./obj_dir/Vip_eth_rx_tb > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Test OK" sim.log || { echo "no result found in sim.log"; exit 1; }
exit 0

//--- tb/ip_eth_rx_tb.sv
// testbench for the IPv4 receiver, frames come from tb/ip_rx_vectors.txt
// record layout: class, byte count, 14 Ethernet header bytes, frame bytes
// frames never carry Ethernet padding beyond the IP length
// sink readies drop at random, the source inserts fixed gaps
`timescale 1ns/1ns

module ip_eth_rx_tb;

    localparam int MEM_SIZE = 1024;
    localparam int WAIT_LIMIT = 200;
    localparam logic [7:0] END_MARK = 8'hff;

    // outcome classes as coded in the vector file
    localparam int CLS_GOOD = 0;
    localparam int CLS_BAD_FORMAT = 1;
    localparam int CLS_BAD_SUM = 2;
    localparam int CLS_SHORT_HDR = 3;
    localparam int CLS_SHORT_PAY = 4;

    logic                 clk;
    logic                 rst_n;
    ip_rx_pkg::eth_hdr_t  s_eth_hdr;
    logic                 s_eth_hdr_valid;
    logic                 s_eth_hdr_ready;
    ip_rx_pkg::pay_beat_t s_pay;
    logic                 s_pay_valid;
    logic                 s_pay_ready;
    ip_rx_pkg::eth_hdr_t  m_eth_hdr;
    ip_rx_pkg::ip_hdr_t   m_ip_hdr;
    logic                 m_hdr_valid;
    logic                 m_hdr_ready;
    ip_rx_pkg::pay_beat_t m_pay;
    logic                 m_pay_valid;
    logic                 m_pay_ready;
    logic                 busy;
    logic                 err_hdr_early;
    logic                 err_pay_early;
    logic                 err_bad_header;
    logic                 err_bad_sum;

    logic [7:0] vec_mem [0:MEM_SIZE-1];
    logic [7:0] frame [0:255];
    integer     seed;
    int         error_count;
    int         timeout_count;
    int         frame_count;
    bit         timed_out;

    // expected outputs in frame order
    ip_rx_pkg::eth_hdr_t  exp_eth_q[$];
    ip_rx_pkg::ip_hdr_t   exp_ip_q[$];
    ip_rx_pkg::pay_beat_t exp_pay_q[$];

    // pulse counts, bit 3 hdr_early, 2 pay_early, 1 bad_header, 0 bad_sum
    int         err_seen [4];
    logic [3:0] err_prev;
    logic [3:0] err_now;

    assign err_now = {err_hdr_early, err_pay_early, err_bad_header, err_bad_sum};

    tb_clkgen u_clkgen (.clk(clk));

    ip_eth_rx dut0 (
        .clk(clk), .rst_n(rst_n),
        .s_eth_hdr(s_eth_hdr), .s_eth_hdr_valid(s_eth_hdr_valid),
        .s_eth_hdr_ready(s_eth_hdr_ready),
        .s_pay(s_pay), .s_pay_valid(s_pay_valid), .s_pay_ready(s_pay_ready),
        .m_eth_hdr(m_eth_hdr), .m_ip_hdr(m_ip_hdr),
        .m_hdr_valid(m_hdr_valid), .m_hdr_ready(m_hdr_ready),
        .m_pay(m_pay), .m_pay_valid(m_pay_valid), .m_pay_ready(m_pay_ready),
        .busy(busy),
        .err_hdr_early(err_hdr_early), .err_pay_early(err_pay_early),
        .err_bad_header(err_bad_header), .err_bad_sum(err_bad_sum)
    );

    // random sink stalls, about one cycle in four
    always @(negedge clk) begin
        m_pay_ready = ($random(seed) & 3) != 0;
        m_hdr_ready = ($random(seed) & 3) != 0;
    end

    always @(posedge clk) begin
        if (rst_n && m_hdr_valid && m_hdr_ready) begin
            assert (exp_ip_q.size() > 0) else begin
                error_count++;
                $display("** Error at %0t: header output with no header expected", $time);
            end
            if (exp_ip_q.size() > 0) begin
                assert (m_ip_hdr == exp_ip_q[0]) else begin
                    error_count++;
                    $display("** Error at %0t: ip header %h, expected %h",
                             $time, m_ip_hdr, exp_ip_q[0]);
                end
                assert (m_eth_hdr == exp_eth_q[0]) else begin
                    error_count++;
                    $display("** Error at %0t: eth header %h, expected %h",
                             $time, m_eth_hdr, exp_eth_q[0]);
                end
                void'(exp_ip_q.pop_front());
                void'(exp_eth_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && m_pay_valid && m_pay_ready) begin
            assert (exp_pay_q.size() > 0) else begin
                error_count++;
                $display("** Error at %0t: payload byte %h with none expected", $time, m_pay.data);
            end
            if (exp_pay_q.size() > 0) begin
                assert (m_pay == exp_pay_q[0]) else begin
                    error_count++;
                    $display("** Error at %0t: payload %h last %b user %b, expected %h %b %b",
                             $time, m_pay.data, m_pay.last, m_pay.user, exp_pay_q[0].data,
                             exp_pay_q[0].last, exp_pay_q[0].user);
                end
                void'(exp_pay_q.pop_front());
            end
        end
    end

    // error outputs must be single-cycle pulses
    always @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < 4; i++) begin
                if (err_now[i]) begin
                    err_seen[i]++;
                    assert (!err_prev[i]) else begin
                        error_count++;
                        $display("** Error at %0t: error output %0d high for two cycles", $time, i);
                    end
                end
            end
            err_prev = err_now;
        end
    end

    // class from the frame bytes alone
    function automatic int classify(input int n);
        logic [31:0] acc;
        int          ip_len;
        if (n <= ip_rx_pkg::IP_HDR_BYTES) begin
            return CLS_SHORT_HDR;
        end
        if (frame[0] != 8'h45) begin
            return CLS_BAD_FORMAT;
        end
        acc = '0;
        for (int i = 0; i < 20; i += 2) begin
            acc = acc + {16'h0000, frame[i], frame[i + 1]};
        end
        acc = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};
        acc = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};
        if (acc[15:0] != 16'hffff) begin
            return CLS_BAD_SUM;
        end
        ip_len = int'({frame[2], frame[3]});
        return (ip_len > n) ? CLS_SHORT_PAY : CLS_GOOD;
    endfunction

    function automatic ip_rx_pkg::ip_hdr_t expect_ip();
        ip_rx_pkg::ip_hdr_t h;
        h.version = frame[0][7:4];
        h.ihl = frame[0][3:0];
        h.dscp = frame[1][7:2];
        h.ecn = frame[1][1:0];
        h.length = {frame[2], frame[3]};
        h.identification = {frame[4], frame[5]};
        h.flags = frame[6][7:5];
        h.fragment_offset = {frame[6][4:0], frame[7]};
        h.ttl = frame[8];
        h.protocol = frame[9];
        h.header_checksum = {frame[10], frame[11]};
        h.source_ip = {frame[12], frame[13], frame[14], frame[15]};
        h.dest_ip = {frame[16], frame[17], frame[18], frame[19]};
        return h;
    endfunction

    function automatic int error_index(input int cls);
        case (cls)
            CLS_SHORT_HDR:  return 3;
            CLS_SHORT_PAY:  return 2;
            CLS_BAD_FORMAT: return 1;
            CLS_BAD_SUM:    return 0;
            default:        return -1;
        endcase
    endfunction

    // entered and left on a falling edge
    task automatic offer_eth_hdr(input ip_rx_pkg::eth_hdr_t hdr);
        int waited;
        waited = 0;
        s_eth_hdr = hdr;
        s_eth_hdr_valid = 1'b1;
        while (!s_eth_hdr_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!s_eth_hdr_ready) begin
            $display("timeout: Ethernet header not accepted within %0d cycles", WAIT_LIMIT);
            timeout_count++;
            timed_out = 1'b1;
            return;
        end
        @(negedge clk);
        s_eth_hdr_valid = 1'b0;
    endtask

    task automatic send_beat(input ip_rx_pkg::pay_beat_t beat);
        int waited;
        waited = 0;
        s_pay = beat;
        s_pay_valid = 1'b1;
        while (!s_pay_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!s_pay_ready) begin
            $display("timeout: payload byte not accepted within %0d cycles", WAIT_LIMIT);
            timeout_count++;
            timed_out = 1'b1;
            return;
        end
        assert (busy) else begin
            error_count++;
            $display("** Error at %0t: busy low while a frame is received", $time);
        end
        @(negedge clk);
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((busy || exp_pay_q.size() > 0 || exp_ip_q.size() > 0) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (busy || exp_pay_q.size() > 0 || exp_ip_q.size() > 0) begin
            $display("timeout: frame %0d outputs still missing after %0d cycles",
                     frame_count, WAIT_LIMIT);
            timeout_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_frame(input int base, output int next_base);
        int                   cls;
        int                   n;
        int                   derived;
        int                   exp_err;
        int                   seen_before [4];
        logic [111:0]         eth_bits;
        ip_rx_pkg::eth_hdr_t  eth;
        ip_rx_pkg::pay_beat_t beat;
        cls = int'(vec_mem[base]);
        n = int'(vec_mem[base + 1]);
        eth_bits = '0;
        for (int i = 0; i < 14; i++) begin
            eth_bits = {eth_bits[103:0], vec_mem[base + 2 + i]};
        end
        eth.dest_mac = eth_bits[111:64];
        eth.src_mac = eth_bits[63:16];
        eth.eth_type = eth_bits[15:0];
        for (int i = 0; i < n; i++) begin
            frame[i] = vec_mem[base + 16 + i];
        end
        next_base = base + 16 + n;

        derived = classify(n);
        assert (derived == cls) else begin
            error_count++;
            $display("** Error at %0t: vector class %0d, frame bytes give %0d", $time, cls, derived);
        end
        // header and payload come out for good and short-payload frames
        if (derived == CLS_GOOD || derived == CLS_SHORT_PAY) begin
            exp_eth_q.push_back(eth);
            exp_ip_q.push_back(expect_ip());
            for (int i = ip_rx_pkg::IP_HDR_BYTES; i < n; i++) begin
                beat.data = frame[i];
                beat.last = (i == n - 1);
                beat.user = (i == n - 1) && (derived == CLS_SHORT_PAY);
                exp_pay_q.push_back(beat);
            end
        end
        exp_err = error_index(derived);
        seen_before = err_seen;

        offer_eth_hdr(eth);
        for (int i = 0; i < n && !timed_out; i++) begin
            if (i % 7 == 5) begin
                s_pay_valid = 1'b0;
                @(negedge clk);
            end
            beat.data = frame[i];
            beat.last = (i == n - 1);
            beat.user = 1'b0;
            send_beat(beat);
        end
        s_pay_valid = 1'b0;
        if (timed_out) begin
            return;
        end
        wait_drained();
        if (timed_out) begin
            return;
        end
        // last error pulse lands one cycle after the deciding byte
        repeat (2) @(negedge clk);
        for (int i = 0; i < 4; i++) begin
            assert (err_seen[i] - seen_before[i] == ((i == exp_err) ? 1 : 0)) else begin
                error_count++;
                $display("** Error at %0t: frame %0d error output %0d pulsed %0d times",
                         $time, frame_count, i, err_seen[i] - seen_before[i]);
            end
        end
        frame_count++;
    endtask

    initial begin
        int addr;
        int next_addr;
        seed = 76851;
        rst_n = 1'b0;
        s_eth_hdr = '0;
        s_eth_hdr_valid = 1'b0;
        s_pay = '0;
        s_pay_valid = 1'b0;
        m_hdr_ready = 1'b0;
        m_pay_ready = 1'b0;
        err_prev = '0;
        error_count = 0;
        timeout_count = 0;
        frame_count = 0;
        timed_out = 1'b0;
        for (int i = 0; i < 4; i++) begin
            err_seen[i] = 0;
        end
        $readmemh("tb/ip_rx_vectors.txt", vec_mem);

        repeat (8) @(posedge clk);
        @(negedge clk);
        assert (!m_hdr_valid && !m_pay_valid && !busy && !s_eth_hdr_ready && !s_pay_ready
                && err_now == 4'b0000) else begin
            error_count++;
            $display("** Error at %0t: outputs not low during reset", $time);
        end
        rst_n = 1'b1;
        @(negedge clk);
        assert (s_eth_hdr_ready) else begin
            error_count++;
            $display("** Error at %0t: s_eth_hdr_ready low one cycle after reset", $time);
        end

        addr = 0;
        while (vec_mem[addr] != END_MARK && !timed_out && addr < MEM_SIZE - 16) begin
            run_frame(addr, next_addr);
            addr = next_addr;
        end
        assert (frame_count > 0 || timed_out) else begin
            error_count++;
            $display("no frames were read from the vector file");
        end

        $display("frames: %0d, errors: %0d, timeouts: %0d", frame_count, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- tb/ip_rx_vectors.txt
// record: class, byte count, 14 Ethernet header bytes, then the frame bytes
// class 0 good, 1 bad format, 2 bad checksum, 3 short header, 4 short payload
// the list ends with ff
// good, 8 payload bytes
00 1c 02 00 00 00 00 01 02 00 00 00 00 aa 08 00
45 00 00 1c 1c 01 40 00 40 11 9b 61 c0 a8 01 0a
c0 a8 01 14 11 22 33 44 55 66 77 88
// checksum off by one
02 18 02 00 00 00 00 02 02 00 00 00 00 aa 08 00
45 00 00 18 1c 02 40 00 40 11 9b 65 c0 a8 01 0a
c0 a8 01 14 de ad be ef
// good frame right after the rejected one
00 1a 02 00 00 00 00 03 02 00 00 00 00 aa 08 00
45 00 00 1a 1c 03 40 00 40 11 9b 61 c0 a8 01 0a
c0 a8 01 14 a0 a1 a2 a3 a4 a5
// version 6
01 18 02 00 00 00 00 04 02 00 00 00 00 aa 08 00
65 00 00 18 1c 04 40 00 40 11 00 00 c0 a8 01 0a
c0 a8 01 14 01 02 03 04
// IHL 6
01 18 02 00 00 00 00 05 02 00 00 00 00 aa 08 00
46 00 00 18 1c 05 40 00 40 11 12 34 c0 a8 01 0a
c0 a8 01 14 05 06 07 08
// last byte at offset 11
03 0c 02 00 00 00 00 06 02 00 00 00 00 aa 08 00
45 00 00 1c 1c 06 40 00 40 11 00 00
// IP length 40, only 26 bytes sent
04 1a 02 00 00 00 00 07 02 00 00 00 00 aa 08 00
45 00 00 28 1c 07 40 00 40 11 9b 4f c0 a8 01 0a
c0 a8 01 14 c1 c2 c3 c4 c5 c6
// good, 12 payload bytes
00 20 02 00 00 00 00 08 02 00 00 00 00 aa 08 00
45 00 00 20 1c 08 40 00 40 11 9b 56 c0 a8 01 0a
c0 a8 01 14 30 31 32 33 34 35 36 37 38 39 3a 3b
// end of records
ff

//--- tb/tb_clkgen.sv
// free-running testbench clock, 40 ns period, starts low
// no enable, runs until the testbench finishes
`timescale 1ns/1ns

module tb_clkgen (
    output logic clk
);

    localparam int HALF_PERIOD = 20;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule
